//--- icache_defines.svh
// Instruction cache sizing

`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

////////////////////
// Bus widths
////////////////////

// Byte address width on both buses
`define ICACHE_ADDR_W 32
// Instruction word width
`define ICACHE_DATA_W 32

////////////////////
// Geometry
////////////////////

// Direct mapped, one line per index
`define ICACHE_LINES 16
// Words per line, one memory beat each
`define ICACHE_WORDS 4

`endif

//--- src/icache_pkg.sv
// Instruction cache types

`include "icache_defines.svh"

package icache_pkg;

    ////////////////////
    // Address split
    ////////////////////

    // Byte offset inside a word
    localparam int BYTE_W   = $clog2(`ICACHE_DATA_W / 8);
    // Word select inside a line
    localparam int WSEL_W   = $clog2(`ICACHE_WORDS);
    // Byte offset inside a line
    localparam int OFFSET_W = BYTE_W + WSEL_W;
    localparam int INDEX_W  = $clog2(`ICACHE_LINES);
    // Whatever is left above index and offset
    localparam int TAG_W    = `ICACHE_ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    // Data of one complete line, word 0 in the low bits
    typedef logic [`ICACHE_WORDS-1:0][`ICACHE_DATA_W-1:0] line_data_t;

    ////////////////////
    // Payloads
    ////////////////////

    // Captured CPU fetch, word aligned
    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
    } cpu_req_t;

    // Refill request, block aligned
    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
    } block_req_t;

    // Completed refill toward the arrays
    typedef struct packed {
        index_t     index;
        tag_t       tag;
        line_data_t data;
    } line_fill_t;

endpackage

//--- src/icache_fetch_port.sv
// CPU fetch port, Wishbone classic slave

`include "icache_defines.svh"

module icache_fetch_port
    import icache_pkg::*;
(
    input  logic                      aclk,
    input  logic                      aresetn,
    // CPU bus
    input  logic                      cpu_cyc,
    input  logic                      cpu_stb,
    input  logic [`ICACHE_ADDR_W-1:0] cpu_adr,
    output logic                      cpu_ack,
    output logic [`ICACHE_DATA_W-1:0] cpu_dat,
    // Lookup side
    output logic                      req_valid,
    output cpu_req_t                  req,
    input  logic                      rsp_hit,
    input  logic [`ICACHE_DATA_W-1:0] rsp_data
);

    // A request is waiting for its hit
    logic req_open;
    // Current stb already acked, wait for it to fall
    logic answered;

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            req_valid <= 1'b0;
            req_open  <= 1'b0;
            answered  <= 1'b0;
            cpu_ack   <= 1'b0;
        end else begin
            // Both are single cycle pulses
            req_valid <= 1'b0;
            cpu_ack   <= 1'b0;
            // Master dropped stb after the ack
            if (answered && !cpu_stb) begin
                answered <= 1'b0;
            end
            // New fetch, only one in flight
            if (cpu_cyc && cpu_stb && !req_open && !answered) begin
                req_valid <= 1'b1;
                req_open  <= 1'b1;
            end
            // Hit ends the access, either first lookup or replay
            if (req_open && rsp_hit) begin
                cpu_ack  <= 1'b1;
                req_open <= 1'b0;
                answered <= 1'b1;
            end
        end
    end

    ////////////////////
    // Payload
    ////////////////////

    always_ff @(posedge aclk) begin
        // Drop the byte offset, fetches are whole words
        if (cpu_cyc && cpu_stb && !req_open && !answered) begin
            req.addr <= {cpu_adr[`ICACHE_ADDR_W-1:BYTE_W], {BYTE_W{1'b0}}};
        end
        // Word returned along with ack
        if (req_open && rsp_hit) begin
            cpu_dat <= rsp_data;
        end
    end

endmodule

//--- src/icache_lookup.sv
// Tag and data arrays with hit detection

`include "icache_defines.svh"

module icache_lookup
    import icache_pkg::*;
(
    input  logic                      aclk,
    input  logic                      aresetn,
    // From the fetch port
    input  logic                      req_valid,
    input  cpu_req_t                  req,
    // Re-read of the pending request after a refill
    input  logic                      replay,
    input  logic                      flush,
    // Line write from the memory master
    input  logic                      fill_valid,
    input  line_fill_t                fill,
    // Lookup result
    output logic                      hit,
    output logic                      miss,
    output logic [`ICACHE_DATA_W-1:0] hit_data,
    output cpu_req_t                  miss_req
);

    ////////////////////
    // Storage
    ////////////////////

    // One valid bit per line
    logic [`ICACHE_LINES-1:0] valid_q;
    tag_t                     tags  [`ICACHE_LINES];
    line_data_t               lines [`ICACHE_LINES];

    ////////////////////
    // Read side
    ////////////////////

    // Request being looked up this cycle
    cpu_req_t              rd_req;
    logic                  rd_en;
    index_t                rd_index;
    tag_t                  rd_tag;
    logic [WSEL_W-1:0]     rd_word;
    logic                  rd_hit;

    // Replay re-reads the request held from the miss
    assign rd_req   = replay ? miss_req : req;
    assign rd_en    = req_valid || replay;

    // Address split: tag, index, word, byte
    assign rd_index = rd_req.addr[OFFSET_W +: INDEX_W];
    assign rd_tag   = rd_req.addr[`ICACHE_ADDR_W-1 -: TAG_W];
    assign rd_word  = rd_req.addr[BYTE_W +: WSEL_W];

    assign rd_hit   = valid_q[rd_index] && (tags[rd_index] == rd_tag);

    // Result flags, one cycle after the read
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            hit  <= 1'b0;
            miss <= 1'b0;
        end else begin
            hit  <= rd_en && rd_hit;
            miss <= rd_en && !rd_hit;
        end
    end

    // Word and request travel with the flags
    always_ff @(posedge aclk) begin
        if (rd_en) begin
            hit_data <= lines[rd_index][rd_word];
            miss_req <= rd_req;
        end
    end

    ////////////////////
    // Write side
    ////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid_q <= '0;
        end else begin
            if (flush) begin
                valid_q <= '0;
            end
            // Fill comes last so a line in flight survives a flush
            if (fill_valid) begin
                valid_q[fill.index] <= 1'b1;
            end
        end
    end

    // Tag and data written together as one line
    always_ff @(posedge aclk) begin
        if (fill_valid) begin
            tags[fill.index]  <= fill.tag;
            lines[fill.index] <= fill.data;
        end
    end

endmodule

//--- src/icache_miss_handler.sv
// Refill sequencer for missed blocks

`include "icache_defines.svh"

module icache_miss_handler
    import icache_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,
    // Lookup result
    input  logic       miss,
    input  cpu_req_t   miss_req,
    // Block request toward the memory master
    output logic       fetch_valid,
    output block_req_t fetch,
    input  logic       fetch_ready,
    // Completed line, shared with the lookup
    input  logic       fill_valid,
    input  line_fill_t fill,
    // Re-read of the missed request
    output logic       replay
);

    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        LOAD      = 2'd1,
        WAIT_FILL = 2'd2
    } state_t;

    state_t state;

    // Fill belongs to the block we asked for
    logic fill_match;

    assign fill_match = fill_valid &&
                        (fill.index == fetch.addr[OFFSET_W +: INDEX_W]) &&
                        (fill.tag == fetch.addr[`ICACHE_ADDR_W-1 -: TAG_W]);

    ////////////////////
    // Sequencer
    ////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state       <= IDLE;
            fetch_valid <= 1'b0;
            replay      <= 1'b0;
        end else begin
            replay <= 1'b0;
            case (state)
                // Wait for a miss from the lookup
                IDLE: begin
                    if (miss) begin
                        fetch_valid <= 1'b1;
                        state       <= LOAD;
                    end
                end
                // Hold the request until the master takes it
                LOAD: begin
                    if (fetch_ready) begin
                        fetch_valid <= 1'b0;
                        state       <= WAIT_FILL;
                    end
                end
                // Line written this cycle, replay reads it next
                WAIT_FILL: begin
                    if (fill_match) begin
                        replay <= 1'b1;
                        state  <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Block aligned address of the missed word
    always_ff @(posedge aclk) begin
        if (state == IDLE && miss) begin
            fetch.addr <= {miss_req.addr[`ICACHE_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        end
    end

endmodule

//--- src/icache_mem_master.sv
// Memory side Wishbone classic master

`include "icache_defines.svh"

module icache_mem_master
    import icache_pkg::*;
(
    input  logic                      aclk,
    input  logic                      aresetn,
    // Block request from the miss handler
    input  logic                      fetch_valid,
    input  block_req_t                fetch,
    output logic                      fetch_ready,
    // Memory bus
    output logic                      mem_cyc,
    output logic                      mem_stb,
    output logic [`ICACHE_ADDR_W-1:0] mem_adr,
    input  logic                      mem_ack,
    input  logic [`ICACHE_DATA_W-1:0] mem_dat,
    // Assembled line
    output logic                      fill_valid,
    output line_fill_t                fill
);

    // Block transfer in progress
    logic              busy;
    // Current beat within the line
    logic [WSEL_W-1:0] beat;
    logic              last_beat;

    // Accept only while no block is running
    assign fetch_ready = !busy && fetch_valid;
    assign last_beat   = (beat == WSEL_W'(`ICACHE_WORDS - 1));

    ////////////////////
    // Bus control
    ////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            busy       <= 1'b0;
            beat       <= '0;
            mem_cyc    <= 1'b0;
            mem_stb    <= 1'b0;
            mem_adr    <= '0;
            fill_valid <= 1'b0;
        end else begin
            fill_valid <= 1'b0;
            if (fetch_ready) begin
                // First beat at the block base
                busy    <= 1'b1;
                beat    <= '0;
                mem_cyc <= 1'b1;
                mem_stb <= 1'b1;
                mem_adr <= fetch.addr;
            end else if (busy && mem_ack) begin
                if (last_beat) begin
                    // Close the cycle and hand the line over
                    busy       <= 1'b0;
                    mem_cyc    <= 1'b0;
                    mem_stb    <= 1'b0;
                    fill_valid <= 1'b1;
                end else begin
                    // cyc stays up, next word follows
                    beat    <= beat + 1'b1;
                    mem_adr <= mem_adr + `ICACHE_ADDR_W'(`ICACHE_DATA_W / 8);
                end
            end
        end
    end

    ////////////////////
    // Line assembly
    ////////////////////

    always_ff @(posedge aclk) begin
        if (fetch_ready) begin
            fill.index <= fetch.addr[OFFSET_W +: INDEX_W];
            fill.tag   <= fetch.addr[`ICACHE_ADDR_W-1 -: TAG_W];
        end
        // Each beat lands in its own word slot
        if (busy && mem_ack) begin
            fill.data[beat] <= mem_dat;
        end
    end

endmodule

//--- src/icache_top.sv
// Instruction cache top level

`include "icache_defines.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      flush,
    // CPU bus, slave side
    input  logic                      cpu_cyc,
    input  logic                      cpu_stb,
    input  logic [`ICACHE_ADDR_W-1:0] cpu_adr,
    output logic                      cpu_ack,
    output logic [`ICACHE_DATA_W-1:0] cpu_dat,
    // Memory bus, master side
    output logic                      mem_cyc,
    output logic                      mem_stb,
    output logic [`ICACHE_ADDR_W-1:0] mem_adr,
    input  logic                      mem_ack,
    input  logic [`ICACHE_DATA_W-1:0] mem_dat
);

    ////////////////////
    // Internal wires
    ////////////////////

    // Fetch port to lookup
    logic                      req_valid;
    cpu_req_t                  req;
    // Lookup result
    logic                      hit;
    logic                      miss;
    logic [`ICACHE_DATA_W-1:0] hit_data;
    cpu_req_t                  miss_req;
    // Refill path
    logic                      replay;
    logic                      fetch_valid;
    logic                      fetch_ready;
    block_req_t                fetch;
    logic                      fill_valid;
    line_fill_t                fill;

    icache_fetch_port u_fetch_port (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .cpu_cyc   (cpu_cyc),
        .cpu_stb   (cpu_stb),
        .cpu_adr   (cpu_adr),
        .cpu_ack   (cpu_ack),
        .cpu_dat   (cpu_dat),
        .req_valid (req_valid),
        .req       (req),
        .rsp_hit   (hit),
        .rsp_data  (hit_data)
    );

    icache_lookup u_lookup (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .req_valid  (req_valid),
        .req        (req),
        .replay     (replay),
        .flush      (flush),
        .fill_valid (fill_valid),
        .fill       (fill),
        .hit        (hit),
        .miss       (miss),
        .hit_data   (hit_data),
        .miss_req   (miss_req)
    );

    icache_miss_handler u_miss_handler (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .miss        (miss),
        .miss_req    (miss_req),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .fetch_ready (fetch_ready),
        .fill_valid  (fill_valid),
        .fill        (fill),
        .replay      (replay)
    );

    icache_mem_master u_mem_master (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .fetch_ready (fetch_ready),
        .mem_cyc     (mem_cyc),
        .mem_stb     (mem_stb),
        .mem_adr     (mem_adr),
        .mem_ack     (mem_ack),
        .mem_dat     (mem_dat),
        .fill_valid  (fill_valid),
        .fill        (fill)
    );

endmodule

//--- dv/icache_checker.sv
// Instruction cache bus checker

`include "icache_defines.svh"

module icache_checker (
    input  logic                      aclk,
    input  logic                      aresetn,
    // CPU bus
    input  logic                      cpu_ack,
    input  logic [`ICACHE_DATA_W-1:0] cpu_dat,
    // Memory bus
    input  logic                      mem_cyc,
    input  logic                      mem_stb,
    input  logic [`ICACHE_ADDR_W-1:0] mem_adr,
    input  logic                      mem_ack,
    // Golden values of the access in progress
    input  logic [`ICACHE_ADDR_W-1:0] exp_addr,
    input  logic [`ICACHE_DATA_W-1:0] exp_data,
    input  int                        exp_beats,
    output int                        errors
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORD_BYTES = `ICACHE_DATA_W / 8;
    localparam int LINE_BYTES = `ICACHE_WORDS * WORD_BYTES;

    // Memory beats seen since the last cpu_ack
    int                        beats;
    // Block base of the golden address
    logic [`ICACHE_ADDR_W-1:0] block_base;
    logic [`ICACHE_ADDR_W-1:0] beat_adr;

    assign block_base = exp_addr & ~(`ICACHE_ADDR_W'(LINE_BYTES - 1));
    assign beat_adr   = block_base + `ICACHE_ADDR_W'(beats * WORD_BYTES);

    always @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            beats  <= 0;
            errors = 0;
        end else begin
            ////////////////////
            // Memory cycle framing
            ////////////////////
            // Strobe only inside an open cycle
            if (mem_stb && !mem_cyc) begin
                $display("[FAIL] %0t: mem_stb high without mem_cyc", $time);
                errors = errors + 1;
            end
            // One cycle spans all four beats of a block
            if (beats > 0 && beats < `ICACHE_WORDS && !mem_cyc) begin
                $display("[FAIL] %0t: mem_cyc dropped after beat %0d of %h",
                         $time, beats, exp_addr);
                errors = errors + 1;
            end
            ////////////////////
            // Memory beats
            ////////////////////
            if (mem_cyc && mem_stb && mem_ack) begin
                if (beats >= `ICACHE_WORDS) begin
                    $display("[FAIL] %0t: extra memory beat at %h for %h",
                             $time, mem_adr, exp_addr);
                    errors = errors + 1;
                end else if (mem_adr != beat_adr) begin
                    $display("[FAIL] %0t: beat %0d address %h, expected %h",
                             $time, beats, mem_adr, beat_adr);
                    errors = errors + 1;
                end
                beats <= beats + 1;
            end
            ////////////////////
            // CPU response
            ////////////////////
            if (cpu_ack) begin
                if (cpu_dat != exp_data) begin
                    $display("[FAIL] %0t: data at %h is %h, expected %h",
                             $time, exp_addr, cpu_dat, exp_data);
                    errors = errors + 1;
                end
                if (beats != exp_beats) begin
                    $display("[FAIL] %0t: read of %h took %0d beats, expected %0d",
                             $time, exp_addr, beats, exp_beats);
                    errors = errors + 1;
                end
                // Block cycle closes before the CPU gets its word
                if (mem_cyc) begin
                    $display("[FAIL] %0t: mem_cyc still high at cpu_ack for %h",
                             $time, exp_addr);
                    errors = errors + 1;
                end
                // Count starts over for the next access
                beats <= 0;
            end
        end
    end

endmodule

//--- dv/icache_tb.sv
// Instruction cache testbench

`include "icache_defines.svh"

module icache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int GOLD_WORDS = 256;
    localparam int TIMEOUT    = 200;
    // Golden operation codes
    localparam int OP_END     = 0;
    localparam int OP_READ    = 1;
    localparam int OP_FLUSH   = 2;

    logic                      aclk;
    logic                      aresetn;
    logic                      flush;
    logic                      cpu_cyc;
    logic                      cpu_stb;
    logic [`ICACHE_ADDR_W-1:0] cpu_adr;
    logic                      cpu_ack;
    logic [`ICACHE_DATA_W-1:0] cpu_dat;
    logic                      mem_cyc;
    logic                      mem_stb;
    logic [`ICACHE_ADDR_W-1:0] mem_adr;
    logic                      mem_ack = 1'b0;
    logic [`ICACHE_DATA_W-1:0] mem_dat = '0;

    // Golden values handed to the checker
    logic [`ICACHE_ADDR_W-1:0] exp_addr;
    logic [`ICACHE_DATA_W-1:0] exp_data;
    int                        exp_beats;

    // Four words per entry: op, address, data, beats
    logic [31:0] golden [GOLD_WORDS];
    int          seed;
    int          check_errors;
    int          run_errors;
    int          accesses;
    // Memory model state
    logic        mem_busy;
    int          mem_wait;

    always #20 aclk = ~aclk;

    icache_top UUT (
        .aclk    (aclk),
        .aresetn (aresetn),
        .flush   (flush),
        .cpu_cyc (cpu_cyc),
        .cpu_stb (cpu_stb),
        .cpu_adr (cpu_adr),
        .cpu_ack (cpu_ack),
        .cpu_dat (cpu_dat),
        .mem_cyc (mem_cyc),
        .mem_stb (mem_stb),
        .mem_adr (mem_adr),
        .mem_ack (mem_ack),
        .mem_dat (mem_dat)
    );

    icache_checker u_checker (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .cpu_ack   (cpu_ack),
        .cpu_dat   (cpu_dat),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_adr   (mem_adr),
        .mem_ack   (mem_ack),
        .exp_addr  (exp_addr),
        .exp_data  (exp_data),
        .exp_beats (exp_beats),
        .errors    (check_errors)
    );

    ////////////////////
    // Memory model
    ////////////////////

    // Ack delay of 0 to 3 cycles
    function automatic int ack_delay();
        int rnd;
        rnd = $random(seed);
        return rnd & 3;
    endfunction

    // Inverted low half above the low half of the address
    function automatic logic [`ICACHE_DATA_W-1:0] mem_word(input logic [`ICACHE_ADDR_W-1:0] adr);
        return {~adr[15:0], adr[15:0]};
    endfunction

    always @(posedge aclk or negedge aresetn) begin
        int delay;
        if (!aresetn) begin
            mem_ack  <= 1'b0;
            mem_busy <= 1'b0;
            mem_wait <= 0;
        end else begin
            mem_ack <= 1'b0;
            // Skip the cycle right after an ack, the address moves then
            if (mem_cyc && mem_stb && !mem_ack) begin
                if (!mem_busy) begin
                    delay = ack_delay();
                    if (delay == 0) begin
                        mem_ack <= 1'b1;
                        mem_dat <= mem_word(mem_adr);
                    end else begin
                        mem_busy <= 1'b1;
                        mem_wait <= delay - 1;
                    end
                end else if (mem_wait == 0) begin
                    mem_busy <= 1'b0;
                    mem_ack  <= 1'b1;
                    mem_dat  <= mem_word(mem_adr);
                end else begin
                    mem_wait <= mem_wait - 1;
                end
            end
        end
    end

    ////////////////////
    // Accesses
    ////////////////////

    // One Wishbone read, held until cpu_ack; returns 0 on a stall
    task automatic cpu_read(input logic [31:0] addr, input logic [31:0] data,
                            input int beats, input int entry, output logic acked);
        int cycles;
        cycles = 0;
        acked  = 1'b0;
        @(posedge aclk);
        cpu_cyc   <= 1'b1;
        cpu_stb   <= 1'b1;
        cpu_adr   <= addr;
        exp_addr  <= addr;
        exp_data  <= data;
        exp_beats <= beats;
        while (!acked && cycles < TIMEOUT) begin
            @(posedge aclk);
            cycles = cycles + 1;
            acked  = cpu_ack;
        end
        cpu_cyc <= 1'b0;
        cpu_stb <= 1'b0;
        if (!acked) begin
            $display("Read of address %h at golden entry %0d got no cpu_ack in %0d cycles",
                     addr, entry, TIMEOUT);
        end
    endtask

    // Single cycle flush pulse
    task automatic flush_cache();
        @(posedge aclk);
        flush <= 1'b1;
        @(posedge aclk);
        flush <= 1'b0;
    endtask

    initial begin
        int          entry;
        logic [31:0] op;
        logic        acked;
        logic        stalled;
        aclk         = 1'b0;
        aresetn      = 1'b0;
        flush        = 1'b0;
        cpu_cyc      = 1'b0;
        cpu_stb      = 1'b0;
        cpu_adr      = '0;
        exp_addr     = '0;
        exp_data     = '0;
        exp_beats    = 0;
        seed         = 32'h8329_6067;
        run_errors   = 0;
        accesses     = 0;
        stalled      = 1'b0;
        entry        = 0;
        for (int i = 0; i < GOLD_WORDS; i++) begin
            golden[i] = '0;
        end
        $readmemh("dv/icache_golden.txt", golden);

        // Reset held for three cycles
        repeat (3) @(posedge aclk);
        aresetn <= 1'b1;

        op = golden[0];
        while (op != OP_END && !stalled && entry < GOLD_WORDS / 4) begin
            if (op == OP_READ) begin
                cpu_read(golden[entry*4+1], golden[entry*4+2], int'(golden[entry*4+3]),
                         entry, acked);
                accesses = accesses + 1;
                if (!acked) begin
                    run_errors = run_errors + 1;
                    stalled    = 1'b1;
                end
            end else if (op == OP_FLUSH) begin
                flush_cache();
            end else begin
                $display("Golden entry %0d has an unknown operation %0h", entry, op);
                run_errors = run_errors + 1;
            end
            entry = entry + 1;
            if (entry < GOLD_WORDS / 4) begin
                op = golden[entry*4];
            end
        end

        // Let the checker see the last response
        repeat (2) @(posedge aclk);
        $display("Accesses: %0d, check errors: %0d, run errors: %0d",
                 accesses, check_errors, run_errors);
        if (check_errors == 0 && run_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- dv/icache_golden.txt
// Columns: op (1 read, 2 flush, 0 end), byte address, expected word, expected beats
// All values hex, one access per line
1 00001000 EFFF1000 4
1 00001010 EFEF1010 4
1 00001020 EFDF1020 4
1 00001030 EFCF1030 4
1 00001040 EFBF1040 4
1 00001050 EFAF1050 4
1 00001060 EF9F1060 4
1 00001070 EF8F1070 4
1 00001080 EF7F1080 4
1 00001090 EF6F1090 4
1 000010A0 EF5F10A0 4
1 000010B0 EF4F10B0 4
1 000010C0 EF3F10C0 4
1 000010D0 EF2F10D0 4
1 000010E0 EF1F10E0 4
1 000010F0 EF0F10F0 4
1 0000100C EFF3100C 0
1 0000101C EFE3101C 0
1 0000102C EFD3102C 0
1 0000103C EFC3103C 0
1 0000104C EFB3104C 0
1 0000105C EFA3105C 0
1 0000106C EF93106C 0
1 0000107C EF83107C 0
1 0000108C EF73108C 0
1 0000109C EF63109C 0
1 000010AC EF5310AC 0
1 000010BC EF4310BC 0
1 000010CC EF3310CC 0
1 000010DC EF2310DC 0
1 000010EC EF1310EC 0
1 000010FC EF0310FC 0
1 00000100 FEFF0100 4
1 00000104 FEFB0104 0
1 00000108 FEF70108 0
1 0000010C FEF3010C 0
1 00000100 FEFF0100 0
1 00000200 FDFF0200 4
1 00000100 FEFF0100 4
1 00000200 FDFF0200 4
1 00000104 FEFB0104 4
1 00000108 FEF70108 0
1 00001054 EFAB1054 0
2 00000000 00000000 0
1 00000108 FEF70108 4
1 00001050 EFAF1050 4
0 00000000 00000000 0

//--- icache.f
+incdir+.
src/icache_pkg.sv
src/icache_fetch_port.sv
src/icache_lookup.sv
src/icache_miss_handler.sv
src/icache_mem_master.sv
src/icache_top.sv
dv/icache_checker.sv
dv/icache_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := icache_tb
FILELIST  := icache.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := icache_defines.svh $(wildcard src/*.sv) $(wildcard dv/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx '\*\* PASS \*\*' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
